// File: verilog.f
+incdir+.
stq_pkg.sv
stq_entry.sv
stq_entry_array.sv
stq_ctrl.sv
stq_fwd_sel.sv
stq_top.sv
stq_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the store queue testbench with Verilator
verilator --binary --timing --assert -f verilog.f --top-module stq_tb -o stq_sim \
  > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/stq_sim > sim.log 2>&1 || echo "simulator returned an error" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || { echo "no result in sim.log"; exit 1; }
exit 0

// File: stq_tb.sv
`timescale 1ns/1ps
`include "stq_cfg.svh"

module stq_tb
  import stq_pkg::*;
();

  localparam int RAND_CYC = 2000;
  localparam int TEST_CYC = 300 + RAND_CYC; // directed part stays well below 300 cycles
  localparam int WD_NS = TEST_CYC * 10 + 1000;

  logic     clk;
  logic     rst;
  logic     st0_en;
  logic     st1_en;
  st_addr_t st0_addr;
  st_addr_t st1_addr;
  logic     upd_en;
  stq_idx_t upd_idx;
  logic     commit_en;
  logic     drain_en;
  logic     excpt;
  ld_chk_t  ld_chk [`STQ_CHK_PORTS];
  ld_res_t  ld_res [`STQ_CHK_PORTS];
  logic     full;
  logic     empty;

  // inputs for the next cycle
  logic     n_st0, n_st1, n_upd, n_cmt, n_drn, n_exc;
  st_addr_t n_a0, n_a1;
  stq_idx_t n_uidx;
  ld_chk_t  n_chk [`STQ_CHK_PORTS];

  // reference model
  st_addr_t m_st [`STQ_ENTRIES];
  logic     m_free [`STQ_ENTRIES];
  logic     m_upd [`STQ_ENTRIES];
  logic     m_passe [`STQ_ENTRIES];
  stq_idx_t m_head, m_cmt, m_tail;
  int       m_count, m_ccnt;
  ld_res_t  exp_res [`STQ_CHK_PORTS];

  logic [31:0] rng_state = 32'd55;
  sub_bnk_t    sub_pool [4] = '{8'h0f, 8'hf0, 8'h3c, 8'hff};
  int          errors = 0;
  int          n_checks = 0;

  stq_top DUT (
    .clk(clk), .rst(rst), .st0_en(st0_en), .st0_addr(st0_addr), .st1_en(st1_en),
    .st1_addr(st1_addr), .upd_en(upd_en), .upd_idx(upd_idx), .commit_en(commit_en),
    .drain_en(drain_en), .excpt(excpt), .ld_chk(ld_chk), .ld_res(ld_res),
    .full(full), .empty(empty)
  );

  always #5 clk = ~clk;

  initial begin
    #(WD_NS);
    $display("watchdog expired before the tests finished");
    $display("=== FAIL ===");
    $finish;
  end

  function automatic logic [31:0] rnd();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // two addresses, each with both parities, so that stores and loads collide often
  function automatic st_addr_t mk_addr(int sel, bytes_t b, int sb);
    st_addr_t a;
    a.addr_eo = 36'h1_0000_0000 + addr_eo_t'((sel >> 1) * 16);
    a.odd     = odd_t'(sel & 1);
    a.bytes   = b;
    a.sub_bnk = sub_pool[sb];
    return a;
  endfunction

  function automatic st_addr_t rnd_addr();
    logic [31:0] r;
    r = rnd();
    return mk_addr(int'(r[1:0]), bytes_t'(r[5:2]), int'(r[7:6]));
  endfunction

  task automatic check_res(string name, ld_res_t got, ld_res_t exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // youngest overlapping store wins, counting back from the tail
  function automatic ld_res_t search(ld_chk_t c);
    ld_res_t  r;
    logic     done;
    logic     ov;
    stq_idx_t k;
    r = '0;
    done = 1'b0;
    for (int j = 1; j <= `STQ_ENTRIES; j++) begin
      k = m_tail - stq_idx_t'(j);
      ov = c.en && !m_free[k] && !m_passe[k] && c.addr.addr_eo == m_st[k].addr_eo
           && c.addr.odd == m_st[k].odd && (c.addr.sub_bnk & m_st[k].sub_bnk) != '0;
      if (ov && !done) begin
        done = 1'b1;
        r.idx = k;
        if (m_upd[k] && (c.addr.bytes & ~m_st[k].bytes) == '0) r.hit = 1'b1;
        else r.partial = 1'b1;
      end
    end
    return r;
  endfunction

  task automatic model_step();
    stq_idx_t w0, w1, cn, ti;
    logic     pe, fe, op, wr;
    int       cc, na;
    w0 = m_tail;
    w1 = m_tail + 3'd1;
    for (int t = 0; t < `STQ_ENTRIES; t++) begin
      ti = stq_idx_t'(t);
      pe = n_cmt && m_cmt == ti;
      fe = n_drn && m_head == ti;
      op = m_passe[t];
      wr = !n_exc && ((n_st0 && w0 == ti) || (n_st1 && w1 == ti));
      if (wr) begin
        m_st[t] = (n_st0 && w0 == ti) ? n_a0 : n_a1;
        m_free[t] = 1'b0;
        m_passe[t] = 1'b0;
        m_upd[t] = 1'b0;
      end
      if (n_upd && n_uidx == ti) m_upd[t] = 1'b1;
      if (pe) m_passe[t] = 1'b1;
      if (fe) begin
        m_free[t] = 1'b1;
        m_passe[t] = 1'b0;
      end
      if (n_exc && !op && !pe) m_free[t] = 1'b1; // uncommitted stores vanish
    end
    cn = m_cmt + stq_idx_t'(n_cmt);
    cc = m_ccnt + int'(n_cmt) - int'(n_drn);
    na = int'(n_st0) + int'(n_st1);
    m_head = m_head + stq_idx_t'(n_drn);
    m_cmt = cn;
    if (n_exc) begin
      m_tail = cn;
      m_count = cc;
    end else begin
      m_tail = m_tail + stq_idx_t'(na);
      m_count = m_count + na - int'(n_drn);
    end
    m_ccnt = cc;
  endtask

  task automatic legalize();
    if (n_st1 && !n_st0) n_st1 = 1'b0;
    if ((`STQ_ENTRIES - m_count) < 2) begin
      n_st0 = 1'b0;
      n_st1 = 1'b0;
    end
    if (m_count - m_ccnt <= 0) n_cmt = 1'b0;
    if (m_ccnt == 0) n_drn = 1'b0;
  endtask

  task automatic cycle();
    legalize();
    @(posedge clk);
    st0_en <= n_st0;
    st1_en <= n_st1;
    st0_addr <= n_a0;
    st1_addr <= n_a1;
    upd_en <= n_upd;
    upd_idx <= n_uidx;
    commit_en <= n_cmt;
    drain_en <= n_drn;
    excpt <= n_exc;
    for (int p = 0; p < `STQ_CHK_PORTS; p++) ld_chk[p] <= n_chk[p];
    @(negedge clk);
    for (int p = 0; p < `STQ_CHK_PORTS; p++) begin
      check_res($sformatf("ld_res[%0d]", p), ld_res[p], exp_res[p]);
    end
    check_flag("full", full, (`STQ_ENTRIES - m_count) < 2);
    check_flag("empty", empty, m_count == 0);
    for (int p = 0; p < `STQ_CHK_PORTS; p++) exp_res[p] = search(n_chk[p]);
    model_step();
    {n_st0, n_st1, n_upd, n_cmt, n_drn, n_exc} = '0;
    for (int p = 0; p < `STQ_CHK_PORTS; p++) n_chk[p].en = 1'b0;
  endtask

  task automatic load(int p, int sel, bytes_t b, int sb);
    n_chk[p].en = 1'b1;
    n_chk[p].addr = mk_addr(sel, b, sb);
  endtask

  task automatic report(string name, int err0);
    $display("test %s done, %0d errors", name, errors - err0);
  endtask

  initial begin
    int e0;
    logic [31:0] r;
    clk = 1'b0;
    rst = 1'b1;
    {st0_en, st1_en, upd_en, commit_en, drain_en, excpt} = '0;
    st0_addr = '0;
    st1_addr = '0;
    upd_idx = '0;
    {n_st0, n_st1, n_upd, n_cmt, n_drn, n_exc} = '0;
    n_a0 = '0;
    n_a1 = '0;
    n_uidx = '0;
    for (int p = 0; p < `STQ_CHK_PORTS; p++) begin
      ld_chk[p] = '0;
      n_chk[p] = '0;
      exp_res[p] = '0;
    end
    for (int t = 0; t < `STQ_ENTRIES; t++) begin
      m_st[t] = '0;
      m_free[t] = 1'b1;
      m_upd[t] = 1'b0;
      m_passe[t] = 1'b0;
    end
    m_head = '0;
    m_cmt = '0;
    m_tail = '0;
    m_count = 0;
    m_ccnt = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    e0 = errors; // covered load after the data strobe
    n_st0 = 1'b1;
    n_a0 = mk_addr(0, 4'hf, 3);
    cycle();
    n_upd = 1'b1;
    n_uidx = m_tail - 3'd1;
    cycle();
    load(0, 0, 4'h3, 0);
    load(1, 0, 4'hc, 1);
    cycle();
    cycle();
    report("forward_hit", e0);

    e0 = errors; // bytes outside the mask, and search before the strobe
    n_st0 = 1'b1;
    n_a0 = mk_addr(1, 4'h3, 2);
    cycle();
    load(0, 1, 4'h1, 2);
    n_upd = 1'b1;
    n_uidx = m_tail - 3'd1;
    cycle();
    load(0, 1, 4'hc, 2);
    load(1, 1, 4'h2, 3);
    cycle();
    cycle();
    report("partial", e0);

    e0 = errors; // youngest of several, wrapping the ring
    for (int i = 0; i < 6; i++) begin
      n_st0 = 1'b1;
      n_st1 = 1'b1;
      n_a0 = mk_addr(2, 4'hf, 3);
      n_a1 = mk_addr(2, 4'h1, 0);
      cycle();
      n_upd = 1'b1;
      n_uidx = m_tail - 3'd2;
      load(0, 2, 4'h1, 0);
      load(1, 2, 4'h3, 3);
      cycle();
      n_upd = 1'b1;
      n_uidx = m_tail - 3'd1;
      load(0, 2, 4'h1, 1);
      cycle();
      load(1, 2, 4'h1, 0);
      repeat (4) begin
        n_cmt = 1'b1;
        n_drn = 1'b1;
        cycle();
      end
    end
    report("youngest_wrap", e0);

    e0 = errors; // passe and drained entries, full and empty
    for (int i = 0; i < 10; i++) begin
      n_cmt = 1'b1;
      load(0, 0, 4'h1, 0);
      load(1, 1, 4'h1, 2);
      cycle();
    end
    for (int i = 0; i < 10; i++) begin
      n_drn = 1'b1;
      load(0, 0, 4'h1, 3);
      cycle();
    end
    for (int i = 0; i < 6; i++) begin
      n_st0 = 1'b1;
      n_st1 = 1'b1;
      n_a0 = mk_addr(i % 4, 4'hf, 3);
      n_a1 = mk_addr((i + 1) % 4, 4'hf, 3);
      load(0, i % 4, 4'h1, 3);
      cycle();
    end
    for (int i = 0; i < 12; i++) begin
      n_cmt = 1'b1;
      n_drn = 1'b1;
      load(1, i % 4, 4'h1, 3);
      cycle();
    end
    report("passe_drain_flags", e0);

    e0 = errors; // exception keeps only committed stores
    for (int i = 0; i < 2; i++) begin
      n_st0 = 1'b1;
      n_st1 = 1'b1;
      n_a0 = mk_addr(3, 4'hf, 3);
      n_a1 = mk_addr(3, 4'hf, 3);
      cycle();
    end
    n_cmt = 1'b1;
    cycle();
    n_exc = 1'b1;
    n_cmt = 1'b1;
    n_st0 = 1'b1;
    n_a0 = mk_addr(3, 4'hf, 3);
    load(0, 3, 4'h1, 3);
    cycle();
    load(0, 3, 4'h1, 3);
    n_drn = 1'b1;
    cycle();
    n_st0 = 1'b1;
    n_a0 = mk_addr(3, 4'h1, 3);
    n_drn = 1'b1;
    load(1, 3, 4'h1, 3);
    cycle();
    load(0, 3, 4'h1, 3);
    cycle();
    repeat (4) begin
      n_cmt = 1'b1;
      n_drn = 1'b1;
      cycle();
    end
    report("exception", e0);

    e0 = errors; // random mix
    for (int i = 0; i < RAND_CYC; i++) begin
      r = rnd();
      n_st0 = r[0] | r[1];
      n_st1 = n_st0 && r[2];
      n_a0 = rnd_addr();
      n_a1 = rnd_addr();
      n_upd = r[3];
      n_uidx = stq_idx_t'(r[6:4]);
      n_cmt = r[7];
      n_drn = r[8];
      n_exc = r[15:11] == 5'd0;
      for (int p = 0; p < `STQ_CHK_PORTS; p++) begin
        n_chk[p].en = r[16 + p] | r[18 + p];
        n_chk[p].addr = rnd_addr();
      end
      cycle();
    end
    cycle();
    report("random", e0);

    $display("%0d checks, %0d errors", n_checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: stq_top.sv
`timescale 1ns/1ps
`include "stq_cfg.svh"

module stq_top
  import stq_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     st0_en,
  input  st_addr_t st0_addr,
  input  logic     st1_en,
  input  st_addr_t st1_addr,
  input  logic     upd_en,
  input  stq_idx_t upd_idx,
  input  logic     commit_en,
  input  logic     drain_en,
  input  logic     excpt,
  input  ld_chk_t  ld_chk [`STQ_CHK_PORTS],
  output ld_res_t  ld_res [`STQ_CHK_PORTS],
  output logic     full,
  output logic     empty
);

  stq_vec_t wrt0_en;
  stq_vec_t wrt1_en;
  stq_vec_t upd_vec;
  stq_vec_t passe_vec;
  stq_vec_t free_vec;
  stq_vec_t entry_free;
  stq_vec_t entry_passe;
  stq_vec_t match [`STQ_CHK_PORTS];
  stq_vec_t partial [`STQ_CHK_PORTS];
  stq_idx_t tail;

  stq_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .excpt       (excpt),
    .st0_en      (st0_en),
    .st1_en      (st1_en),
    .upd_en      (upd_en),
    .upd_idx     (upd_idx),
    .commit_en   (commit_en),
    .drain_en    (drain_en),
    .entry_free  (entry_free),
    .entry_passe (entry_passe),
    .wrt0_en     (wrt0_en),
    .wrt1_en     (wrt1_en),
    .upd_vec     (upd_vec),
    .passe_vec   (passe_vec),
    .free_vec    (free_vec),
    .tail        (tail),
    .full        (full),
    .empty       (empty)
  );

  stq_entry_array u_array (
    .clk       (clk),
    .rst       (rst),
    .excpt     (excpt),
    .wrt0_en   (wrt0_en),
    .wrt1_en   (wrt1_en),
    .wrt0_addr (st0_addr),
    .wrt1_addr (st1_addr),
    .upd_en    (upd_vec),
    .passe_en  (passe_vec),
    .free_en   (free_vec),
    .chk       (ld_chk),
    .match     (match),
    .partial   (partial),
    .free      (entry_free),
    .passe     (entry_passe)
  );

  stq_fwd_sel u_fwd_sel (
    .clk     (clk),
    .rst     (rst),
    .tail    (tail),
    .match   (match),
    .partial (partial),
    .ld_res  (ld_res)
  );

endmodule

// File: stq_fwd_sel.sv
`timescale 1ns/1ps
`include "stq_cfg.svh"

module stq_fwd_sel
  import stq_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  stq_idx_t tail,
  input  stq_vec_t match [`STQ_CHK_PORTS],
  input  stq_vec_t partial [`STQ_CHK_PORTS],
  output ld_res_t  ld_res [`STQ_CHK_PORTS]
);

  logic [`STQ_CHK_PORTS-1:0] found;
  stq_idx_t                  sel [`STQ_CHK_PORTS];

  // walk from the tail slot upward, the last hit is the youngest store
  always_comb begin : pick
    stq_idx_t k;
    for (int p = 0; p < `STQ_CHK_PORTS; p++) begin
      found[p] = 1'b0;
      sel[p]   = '0;
      for (int i = 0; i < `STQ_ENTRIES; i++) begin
        k = tail + stq_idx_t'(i);
        if (match[p][k] || partial[p][k]) begin
          found[p] = 1'b1;
          sel[p]   = k;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < `STQ_CHK_PORTS; p++) begin
        ld_res[p] <= '0;
      end
    end else begin
      for (int p = 0; p < `STQ_CHK_PORTS; p++) begin
        ld_res[p].hit     <= found[p] && match[p][sel[p]];
        ld_res[p].partial <= found[p] && !match[p][sel[p]];
        ld_res[p].idx     <= sel[p];
      end
    end
  end

endmodule

// File: stq_ctrl.sv
`timescale 1ns/1ps
`include "stq_cfg.svh"

module stq_ctrl
  import stq_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     excpt,
  input  logic     st0_en,
  input  logic     st1_en,
  input  logic     upd_en,
  input  stq_idx_t upd_idx,
  input  logic     commit_en,
  input  logic     drain_en,
  input  stq_vec_t entry_free,
  input  stq_vec_t entry_passe,
  output stq_vec_t wrt0_en,
  output stq_vec_t wrt1_en,
  output stq_vec_t upd_vec,
  output stq_vec_t passe_vec,
  output stq_vec_t free_vec,
  output stq_idx_t tail,
  output logic     full,
  output logic     empty
);

  localparam int CNT_W = $clog2(`STQ_ENTRIES) + 1;

  stq_idx_t           head;  // oldest entry, next to drain
  stq_idx_t           cmt;   // oldest uncommitted entry
  stq_idx_t           cmt_nxt;
  stq_idx_t           tail_p1;
  logic [CNT_W-1:0]   count; // occupied entries
  logic [CNT_W-1:0]   ccnt;  // committed but not drained
  logic [CNT_W-1:0]   ccnt_nxt;
  logic [1:0]         n_alloc;

  assign n_alloc = excpt ? 2'd0 : {1'b0, st0_en} + {1'b0, st1_en};
  assign tail_p1 = tail + 1'b1;
  assign cmt_nxt = cmt + stq_idx_t'(commit_en);
  assign ccnt_nxt = ccnt + CNT_W'(commit_en) - CNT_W'(drain_en);

  assign wrt0_en   = (st0_en && !excpt) ? stq_vec_t'(1) << tail : '0;
  assign wrt1_en   = (st1_en && !excpt) ? stq_vec_t'(1) << tail_p1 : '0;
  assign upd_vec   = upd_en ? stq_vec_t'(1) << upd_idx : '0;
  assign passe_vec = commit_en ? stq_vec_t'(1) << cmt : '0;
  assign free_vec  = drain_en ? stq_vec_t'(1) << head : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      cmt   <= '0;
      tail  <= '0;
      count <= '0;
      ccnt  <= '0;
    end else begin
      head <= head + stq_idx_t'(drain_en);
      cmt  <= cmt_nxt;
      ccnt <= ccnt_nxt;
      if (excpt) begin
        tail  <= cmt_nxt; // only committed stores remain
        count <= ccnt_nxt;
      end else begin
        tail  <= tail + stq_idx_t'(n_alloc);
        count <= count + CNT_W'(n_alloc) - CNT_W'(drain_en);
      end
    end
  end

  assign full  = count >= CNT_W'(`STQ_ENTRIES - 1); // room for a pair no longer guaranteed
  assign empty = count == '0;

  a_alloc_full: assert property (@(posedge clk) disable iff (rst)
    (st0_en || st1_en) && !excpt |-> !full);

  a_alloc_slot: assert property (@(posedge clk) disable iff (rst)
    st0_en && !excpt |-> entry_free[tail] && (!st1_en || entry_free[tail_p1]));

  a_drain_passe: assert property (@(posedge clk) disable iff (rst)
    drain_en |-> entry_passe[head]);

endmodule

// File: stq_entry_array.sv
`timescale 1ns/1ps
`include "stq_cfg.svh"

module stq_entry_array
  import stq_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     excpt,
  input  stq_vec_t wrt0_en,
  input  stq_vec_t wrt1_en,
  input  st_addr_t wrt0_addr,
  input  st_addr_t wrt1_addr,
  input  stq_vec_t upd_en,
  input  stq_vec_t passe_en,
  input  stq_vec_t free_en,
  input  ld_chk_t  chk [`STQ_CHK_PORTS],
  output stq_vec_t match [`STQ_CHK_PORTS],
  output stq_vec_t partial [`STQ_CHK_PORTS],
  output stq_vec_t free,
  output stq_vec_t passe
);

  logic [`STQ_CHK_PORTS-1:0] ent_match [`STQ_ENTRIES];
  logic [`STQ_CHK_PORTS-1:0] ent_partial [`STQ_ENTRIES];

  for (genvar t = 0; t < `STQ_ENTRIES; t++) begin : g_ent
    stq_entry u_entry (
      .clk       (clk),
      .rst       (rst),
      .excpt     (excpt),
      .wrt0_en   (wrt0_en[t]),
      .wrt1_en   (wrt1_en[t]),
      .wrt0_addr (wrt0_addr),
      .wrt1_addr (wrt1_addr),
      .upd_en    (upd_en[t]),
      .passe_en  (passe_en[t]),
      .free_en   (free_en[t]),
      .chk       (chk),
      .match     (ent_match[t]),
      .partial   (ent_partial[t]),
      .free      (free[t]),
      .passe     (passe[t])
    );
  end

  // entry-major to port-major
  always_comb begin
    for (int p = 0; p < `STQ_CHK_PORTS; p++) begin
      for (int t = 0; t < `STQ_ENTRIES; t++) begin
        match[p][t]   = ent_match[t][p];
        partial[p][t] = ent_partial[t][p];
      end
    end
  end

endmodule

// File: stq_entry.sv
`timescale 1ns/1ps
`include "stq_cfg.svh"

module stq_entry
  import stq_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      excpt,
  input  logic                      wrt0_en,
  input  logic                      wrt1_en,
  input  st_addr_t                  wrt0_addr,
  input  st_addr_t                  wrt1_addr,
  input  logic                      upd_en,
  input  logic                      passe_en,
  input  logic                      free_en,
  input  ld_chk_t                   chk [`STQ_CHK_PORTS],
  output logic [`STQ_CHK_PORTS-1:0] match,
  output logic [`STQ_CHK_PORTS-1:0] partial,
  output logic                      free,
  output logic                      passe
);

  st_addr_t st;
  logic     upd; // store data has arrived

  always_ff @(posedge clk) begin
    if (wrt0_en) begin
      st <= wrt0_addr;
    end else if (wrt1_en) begin
      st <= wrt1_addr;
    end
  end

  // later statements take priority over earlier ones
  always_ff @(posedge clk) begin
    if (rst) begin
      free  <= 1'b1;
      upd   <= 1'b0;
      passe <= 1'b0;
    end else begin
      if (wrt0_en || wrt1_en) begin
        free  <= 1'b0;
        passe <= 1'b0;
        upd   <= 1'b0;
      end
      if (upd_en) begin
        upd <= 1'b1;
      end
      if (passe_en) begin
        passe <= 1'b1;
      end
      if (free_en) begin
        free  <= 1'b1;
        passe <= 1'b0;
      end
      // a store committing in the exception cycle survives, as the tail rewinds past it
      if (excpt && !passe && !passe_en) begin
        free <= 1'b1;
      end
    end
  end

  for (genvar p = 0; p < `STQ_CHK_PORTS; p++) begin : g_port
    logic overlap;
    logic covered;

    assign overlap = chk[p].en && !free && !passe
                     && chk[p].addr.addr_eo == st.addr_eo
                     && chk[p].addr.odd == st.odd
                     && (chk[p].addr.sub_bnk & st.sub_bnk) != '0;
    assign covered = upd && (chk[p].addr.bytes & ~st.bytes) == '0; // every load byte present
    assign match[p] = overlap && covered;
    assign partial[p] = overlap && !covered;
  end

  // the controller places the two stores of a cycle in different slots
  a_one_wrt: assert property (@(posedge clk) disable iff (rst) !(wrt0_en && wrt1_en));

endmodule

// File: stq_pkg.sv
`include "stq_cfg.svh"

package stq_pkg;

  typedef logic [`STQ_ADDR_W-1:0] addr_eo_t;
  typedef logic [2:0] odd_t;      // bank parity
  typedef logic [3:0] bytes_t;    // bytes touched within the word
  typedef logic [7:0] sub_bnk_t;  // sub-banks touched

  typedef logic [$clog2(`STQ_ENTRIES)-1:0] stq_idx_t;
  typedef logic [`STQ_ENTRIES-1:0] stq_vec_t; // one bit per entry

  // address side of one store, also the search key of a load
  typedef struct packed {
    addr_eo_t addr_eo;
    odd_t     odd;
    bytes_t   bytes;
    sub_bnk_t sub_bnk;
  } st_addr_t;

  typedef struct packed {
    logic     en;
    st_addr_t addr;
  } ld_chk_t;

  typedef struct packed {
    logic     hit;     // youngest overlap can forward
    logic     partial; // youngest overlap blocks the load
    stq_idx_t idx;
  } ld_res_t;

endpackage

// File: stq_cfg.svh
`ifndef STQ_CFG_SVH
`define STQ_CFG_SVH

// store queue sizing
`define STQ_ENTRIES 8   // ring depth, power of two
`define STQ_ADDR_W 36   // even/odd address width
`define STQ_CHK_PORTS 2 // load search ports

`endif
